// ==== files.f ====
hdl/udp_proto_pkg.sv
hdl/echo_buf_pkg.sv
hdl/sync_fifo.sv
hdl/udp_rx_filter.sv
hdl/udp_tx_sequencer.sv
hdl/udp_echo_top.sv
verification/udp_echo_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the UDP echo testbench with Verilator, runs it and checks the result

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f files.f --top-module udp_echo_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vudp_echo_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Test OK"; then
    exit 0
fi
exit 1

// ==== verification/udp_echo_tb.sv ====
// Testbench for the UDP echo path with a reference model for the expected replies
// Admission checks rely on idle gaps between datagrams so the buffers have settled
`timescale 1ns/1ps

module udp_echo_tb;

    logic                     clk;
    logic                     rst;
    logic                     i_hdr_valid;
    udp_proto_pkg::ip_addr_t  i_src_ip;
    udp_proto_pkg::udp_port_t i_src_port;
    udp_proto_pkg::udp_port_t i_dst_port;
    udp_proto_pkg::udp_len_t  i_length;
    logic                     i_pay_valid;
    logic [7:0]               i_pay_data;
    logic                     i_pay_last;
    logic                     i_hdr_ready;
    logic                     i_pay_ready;
    logic                     o_hdr_valid;
    udp_proto_pkg::ip_addr_t  o_dst_ip;
    udp_proto_pkg::udp_port_t o_src_port;
    udp_proto_pkg::udp_port_t o_dst_port;
    udp_proto_pkg::udp_len_t  o_length;
    logic                     o_pay_valid;
    logic [7:0]               o_pay_data;
    logic                     o_pay_last;

    // Expected replies in arrival order
    echo_buf_pkg::reply_hdr_t exp_hdr[$];
    logic [7:0]               exp_bytes[$];
    echo_buf_pkg::reply_hdr_t exp_rep;

    int errors;
    int ready_mode;
    int bytes_left;
    // Model occupancy counters updated by the sender and the monitor
    int admitted_bytes;
    int admitted_hdrs;
    int drained_bytes;
    int popped_hdrs;

    logic        hdr_held;
    logic        pay_held;
    logic        hdr_valid_q;
    logic [79:0] held_hdr;
    logic [8:0]  held_pay;

    udp_echo_top u_udp_echo_top (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic echo_buf_pkg::reply_hdr_t echo_reply(
        input udp_proto_pkg::ip_addr_t ip, input udp_proto_pkg::udp_port_t sport,
        input udp_proto_pkg::udp_port_t dport, input udp_proto_pkg::udp_len_t len);
        echo_buf_pkg::reply_hdr_t rep;
        rep.dst_ip   = ip;
        rep.src_port = dport;
        rep.dst_port = sport;
        rep.length   = len;
        return rep;
    endfunction

    // One header may sit at the output while the rest wait in the queue
    function automatic bit admits(input udp_proto_pkg::udp_port_t dport, input int nbytes);
        int bytes_used;
        int hdrs_used;
        bytes_used = admitted_bytes - drained_bytes;
        hdrs_used  = admitted_hdrs - popped_hdrs;
        return (dport == udp_proto_pkg::ECHO_PORT) &&
               (nbytes <= echo_buf_pkg::PAYLOAD_DEPTH - bytes_used) &&
               (hdrs_used < echo_buf_pkg::HDR_DEPTH);
    endfunction

    task automatic check_value(input string name, input logic [79:0] got,
                               input logic [79:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("** Error: %s = %0h, expected %0h", name, got, exp);
        end
    endtask

    task automatic send_dgram(input udp_proto_pkg::ip_addr_t ip,
                              input udp_proto_pkg::udp_port_t sport,
                              input udp_proto_pkg::udp_port_t dport,
                              input int nbytes, input bit gaps, input int idle);
        udp_proto_pkg::udp_len_t len;
        bit                      ok;
        logic [7:0]              b;
        int                      g;
        len = udp_proto_pkg::udp_len_t'(nbytes) + udp_proto_pkg::UDP_HDR_BYTES;
        @(posedge clk);
        ok = admits(dport, nbytes);
        if (ok) begin
            exp_hdr.push_back(echo_reply(ip, sport, dport, len));
            admitted_bytes += nbytes;
            admitted_hdrs++;
        end
        i_hdr_valid <= 1'b1;
        i_src_ip    <= ip;
        i_src_port  <= sport;
        i_dst_port  <= dport;
        i_length    <= len;
        for (int i = 0; i < nbytes; i++) begin
            @(posedge clk);
            i_hdr_valid <= 1'b0;
            g = gaps ? int'($urandom_range(2, 0)) : 0;
            if (g > 0) begin
                i_pay_valid <= 1'b0;
                i_pay_last  <= 1'b0;
                repeat (g) @(posedge clk);
            end
            b = 8'($urandom);
            i_pay_valid <= 1'b1;
            i_pay_data  <= b;
            i_pay_last  <= (i == nbytes - 1);
            if (ok) begin
                exp_bytes.push_back(b);
            end
        end
        @(posedge clk);
        i_pay_valid <= 1'b0;
        i_pay_last  <= 1'b0;
        repeat (idle) @(posedge clk);
    endtask

    task automatic wait_drain(input int max_cycles);
        int n;
        n = 0;
        while ((exp_hdr.size() != 0 || exp_bytes.size() != 0 || o_hdr_valid || o_pay_valid)
               && n < max_cycles) begin
            @(negedge clk);
            n++;
        end
        assert (exp_hdr.size() == 0 && exp_bytes.size() == 0) else begin
            errors++;
            $display("Timeout: %0d expected replies still missing", exp_hdr.size());
        end
    endtask

    // Ready pattern 0 holds both low, 1 holds both high and 2 toggles them randomly
    always @(posedge clk) begin
        if (ready_mode == 0) begin
            i_hdr_ready <= 1'b0;
            i_pay_ready <= 1'b0;
        end else if (ready_mode == 1) begin
            i_hdr_ready <= 1'b1;
            i_pay_ready <= 1'b1;
        end else begin
            i_hdr_ready <= 1'($urandom_range(1, 0));
            i_pay_ready <= 1'($urandom_range(1, 0));
        end
    end

    // Monitor samples mid-cycle where every output has settled
    always @(negedge clk) begin
        if (rst) begin
            hdr_held    = 1'b0;
            pay_held    = 1'b0;
            hdr_valid_q = 1'b0;
            bytes_left  = 0;
        end else begin
            if (hdr_held) begin
                check_value("o_hdr_valid", o_hdr_valid, 1);
                check_value("{o_dst_ip,o_src_port,o_dst_port,o_length}",
                            {o_dst_ip, o_src_port, o_dst_port, o_length}, held_hdr);
            end
            if (pay_held) begin
                check_value("o_pay_valid", o_pay_valid, 1);
                check_value("{o_pay_last,o_pay_data}", {o_pay_last, o_pay_data}, held_pay);
            end
            if (o_hdr_valid && !hdr_valid_q) begin
                popped_hdrs++;
            end
            hdr_valid_q = o_hdr_valid;
            if (o_hdr_valid && i_hdr_ready) begin
                assert (exp_hdr.size() > 0) else begin
                    errors++;
                    $display("Unexpected reply header from the DUT");
                end
                if (exp_hdr.size() > 0) begin
                    exp_rep = exp_hdr.pop_front();
                    check_value("o_dst_ip", o_dst_ip, exp_rep.dst_ip);
                    check_value("o_src_port", o_src_port, exp_rep.src_port);
                    check_value("o_dst_port", o_dst_port, exp_rep.dst_port);
                    check_value("o_length", o_length, exp_rep.length);
                    bytes_left = int'(exp_rep.length - udp_proto_pkg::UDP_HDR_BYTES);
                end
            end
            if (o_pay_valid && i_pay_ready) begin
                drained_bytes++;
                assert (bytes_left > 0 && exp_bytes.size() > 0) else begin
                    errors++;
                    $display("Unexpected payload byte outside a reply");
                end
                if (bytes_left > 0 && exp_bytes.size() > 0) begin
                    check_value("o_pay_data", o_pay_data, exp_bytes.pop_front());
                    check_value("o_pay_last", o_pay_last, (bytes_left == 1));
                    bytes_left--;
                end
            end
            hdr_held = o_hdr_valid && !i_hdr_ready;
            held_hdr = {o_dst_ip, o_src_port, o_dst_port, o_length};
            pay_held = o_pay_valid && !i_pay_ready;
            held_pay = {o_pay_last, o_pay_data};
        end
    end

    initial begin
        void'($urandom(73386));
        errors         = 0;
        ready_mode     = 1;
        admitted_bytes = 0;
        admitted_hdrs  = 0;
        drained_bytes  = 0;
        popped_hdrs    = 0;
        rst            = 1'b1;
        i_hdr_valid    = 1'b0;
        i_src_ip       = '0;
        i_src_port     = '0;
        i_dst_port     = '0;
        i_length       = '0;
        i_pay_valid    = 1'b0;
        i_pay_data     = '0;
        i_pay_last     = 1'b0;
        i_hdr_ready    = 1'b0;
        i_pay_ready    = 1'b0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        // Quiet outputs after reset
        repeat (20) begin
            @(negedge clk);
            check_value("o_hdr_valid", o_hdr_valid, 0);
            check_value("o_pay_valid", o_pay_valid, 0);
        end

        send_dgram(32'h0a000105, 16'd5000, udp_proto_pkg::ECHO_PORT, 16, 1'b0, 2);
        wait_drain(500);

        // Other port is dropped and the next echo still works
        send_dgram(32'h0a000106, 16'd5001, 16'd7, 10, 1'b0, 2);
        send_dgram(32'hc0a80011, 16'd6000, udp_proto_pkg::ECHO_PORT, 9, 1'b0, 2);
        wait_drain(500);

        ready_mode = 2;
        for (int k = 0; k < 4; k++) begin
            send_dgram(32'($urandom), 16'($urandom), udp_proto_pkg::ECHO_PORT,
                       int'($urandom_range(12, 1)), 1'b1, 2);
        end
        wait_drain(3000);

        // Payload buffer overflow drops the second datagram
        ready_mode = 0;
        send_dgram(32'h0a000201, 16'd7000, udp_proto_pkg::ECHO_PORT, 40, 1'b0, 6);
        send_dgram(32'h0a000202, 16'd7001, udp_proto_pkg::ECHO_PORT, 30, 1'b0, 6);
        @(negedge clk);
        ready_mode = 1;
        wait_drain(1000);

        // One reply waits at the output and four fill the header queue so the sixth is dropped
        ready_mode = 0;
        for (int k = 0; k < 6; k++) begin
            send_dgram(32'h0a000300 + 32'(k), 16'd8000, udp_proto_pkg::ECHO_PORT, 4, 1'b0, 6);
        end
        @(negedge clk);
        ready_mode = 1;
        wait_drain(1000);

        repeat (50) @(negedge clk);
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== hdl/udp_echo_top.sv ====
// UDP echo for parsed datagrams, replies to the echo port with swapped addresses
// Input has no back-pressure, datagrams that do not fit are dropped whole
`timescale 1ns/1ps

module udp_echo_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     i_hdr_valid,
    input  udp_proto_pkg::ip_addr_t  i_src_ip,
    input  udp_proto_pkg::udp_port_t i_src_port,
    input  udp_proto_pkg::udp_port_t i_dst_port,
    input  udp_proto_pkg::udp_len_t  i_length,
    input  logic                     i_pay_valid,
    input  logic [7:0]               i_pay_data,
    input  logic                     i_pay_last,
    input  logic                     i_hdr_ready,
    input  logic                     i_pay_ready,
    output logic                     o_hdr_valid,
    output udp_proto_pkg::ip_addr_t  o_dst_ip,
    output udp_proto_pkg::udp_port_t o_src_port,
    output udp_proto_pkg::udp_port_t o_dst_port,
    output udp_proto_pkg::udp_len_t  o_length,
    output logic                     o_pay_valid,
    output logic [7:0]               o_pay_data,
    output logic                     o_pay_last
);

    // Filter to buffers
    logic                                    payload_wr;
    logic [7:0]                              payload_wr_data;
    logic [echo_buf_pkg::PAYLOAD_CNT_W-1:0]  payload_free;
    logic                                    hdr_wr;
    echo_buf_pkg::reply_hdr_t                hdr_wr_data;
    logic                                    hdr_full;

    // Buffers to sequencer
    echo_buf_pkg::reply_hdr_t                hdr_rd_data;
    logic                                    hdr_empty;
    logic                                    hdr_rd;
    logic                                    payload_rd;
    logic [7:0]                              payload_rd_data;

    udp_rx_filter u_rx_filter (
        .clk            (clk),
        .rst            (rst),
        .i_hdr_valid    (i_hdr_valid),
        .i_src_ip       (i_src_ip),
        .i_src_port     (i_src_port),
        .i_dst_port     (i_dst_port),
        .i_length       (i_length),
        .i_pay_valid    (i_pay_valid),
        .i_pay_data     (i_pay_data),
        .i_pay_last     (i_pay_last),
        .i_payload_free (payload_free),
        .i_hdr_full     (hdr_full),
        .o_payload_wr   (payload_wr),
        .o_payload_data (payload_wr_data),
        .o_hdr_wr       (hdr_wr),
        .o_hdr_data     (hdr_wr_data)
    );

    sync_fifo #(
        .WIDTH ($bits(echo_buf_pkg::reply_hdr_t)),
        .DEPTH (echo_buf_pkg::HDR_DEPTH)
    ) u_hdr_fifo (
        .clk       (clk),
        .rst       (rst),
        .i_wr      (hdr_wr),
        .i_wr_data (hdr_wr_data),
        .i_rd      (hdr_rd),
        .o_rd_data (hdr_rd_data),
        .o_empty   (hdr_empty),
        .o_full    (hdr_full),
        .o_free    ()
    );

    // Empty and full are not needed here, admission works from o_free
    sync_fifo #(
        .WIDTH (8),
        .DEPTH (echo_buf_pkg::PAYLOAD_DEPTH)
    ) u_payload_fifo (
        .clk       (clk),
        .rst       (rst),
        .i_wr      (payload_wr),
        .i_wr_data (payload_wr_data),
        .i_rd      (payload_rd),
        .o_rd_data (payload_rd_data),
        .o_empty   (),
        .o_full    (),
        .o_free    (payload_free)
    );

    udp_tx_sequencer u_tx_sequencer (
        .clk            (clk),
        .rst            (rst),
        .i_hdr_empty    (hdr_empty),
        .i_hdr_data     (hdr_rd_data),
        .i_payload_data (payload_rd_data),
        .i_hdr_ready    (i_hdr_ready),
        .i_pay_ready    (i_pay_ready),
        .o_hdr_rd       (hdr_rd),
        .o_payload_rd   (payload_rd),
        .o_hdr_valid    (o_hdr_valid),
        .o_dst_ip       (o_dst_ip),
        .o_src_port     (o_src_port),
        .o_dst_port     (o_dst_port),
        .o_length       (o_length),
        .o_pay_valid    (o_pay_valid),
        .o_pay_data     (o_pay_data),
        .o_pay_last     (o_pay_last)
    );

endmodule

// ==== hdl/udp_tx_sequencer.sv ====
// Sends one queued reply, header first and then its payload bytes
// Payload FIFO holds the whole datagram before its header is queued
`timescale 1ns/1ps

module udp_tx_sequencer (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     i_hdr_empty,
    input  echo_buf_pkg::reply_hdr_t i_hdr_data,
    input  logic [7:0]               i_payload_data,
    input  logic                     i_hdr_ready,
    input  logic                     i_pay_ready,
    output logic                     o_hdr_rd,
    output logic                     o_payload_rd,
    output logic                     o_hdr_valid,
    output udp_proto_pkg::ip_addr_t  o_dst_ip,
    output udp_proto_pkg::udp_port_t o_src_port,
    output udp_proto_pkg::udp_port_t o_dst_port,
    output udp_proto_pkg::udp_len_t  o_length,
    output logic                     o_pay_valid,
    output logic [7:0]               o_pay_data,
    output logic                     o_pay_last
);

    echo_buf_pkg::tx_state_t  state;
    udp_proto_pkg::udp_len_t  pay_left;

    assign o_hdr_rd     = (state == echo_buf_pkg::TX_IDLE) && !i_hdr_empty;
    assign o_pay_valid  = (state == echo_buf_pkg::TX_PAYLOAD);
    assign o_pay_data   = i_payload_data;
    assign o_pay_last   = (pay_left == 16'd1);
    assign o_payload_rd = o_pay_valid && i_pay_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= echo_buf_pkg::TX_IDLE;
            o_hdr_valid <= 1'b0;
            pay_left    <= '0;
        end else begin
            case (state)
                echo_buf_pkg::TX_IDLE: begin
                    if (!i_hdr_empty) begin
                        o_hdr_valid <= 1'b1;
                        state       <= echo_buf_pkg::TX_HEADER;
                    end
                end
                echo_buf_pkg::TX_HEADER: begin
                    if (i_hdr_ready) begin
                        o_hdr_valid <= 1'b0;
                        pay_left    <= o_length - udp_proto_pkg::UDP_HDR_BYTES;
                        state       <= echo_buf_pkg::TX_PAYLOAD;
                    end
                end
                echo_buf_pkg::TX_PAYLOAD: begin
                    if (i_pay_ready) begin
                        pay_left <= pay_left - 1'b1;
                        if (o_pay_last) begin
                            state <= echo_buf_pkg::TX_IDLE;
                        end
                    end
                end
                default: state <= echo_buf_pkg::TX_IDLE;
            endcase
        end
    end

    // Header fields captured on the pop, stable while o_hdr_valid waits
    always_ff @(posedge clk) begin
        if (o_hdr_rd) begin
            o_dst_ip   <= i_hdr_data.dst_ip;
            o_src_port <= i_hdr_data.src_port;
            o_dst_port <= i_hdr_data.dst_port;
            o_length   <= i_hdr_data.length;
        end
    end

endmodule

// ==== hdl/udp_rx_filter.sv ====
// Admits echo-port datagrams that fit the buffers, drops all others whole
// Payload byte count must equal the UDP length minus 8 and be at least one
`timescale 1ns/1ps

module udp_rx_filter (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic                                      i_hdr_valid,
    input  udp_proto_pkg::ip_addr_t                   i_src_ip,
    input  udp_proto_pkg::udp_port_t                  i_src_port,
    input  udp_proto_pkg::udp_port_t                  i_dst_port,
    input  udp_proto_pkg::udp_len_t                   i_length,
    input  logic                                      i_pay_valid,
    input  logic [7:0]                                i_pay_data,
    input  logic                                      i_pay_last,
    input  logic [echo_buf_pkg::PAYLOAD_CNT_W-1:0]    i_payload_free,
    input  logic                                      i_hdr_full,
    output logic                                      o_payload_wr,
    output logic [7:0]                                o_payload_data,
    output logic                                      o_hdr_wr,
    output echo_buf_pkg::reply_hdr_t                  o_hdr_data
);

    echo_buf_pkg::rx_state_t                  state;
    udp_proto_pkg::udp_len_t                  pay_len;
    logic [echo_buf_pkg::PAYLOAD_CNT_W-1:0]   free_now;
    logic                                     admit;
    logic                                     recheck;

    assign pay_len = i_length - udp_proto_pkg::UDP_HDR_BYTES;

    // A byte still in flight to the payload FIFO is not yet in its count
    assign free_now = o_payload_wr ? i_payload_free - 1'b1 : i_payload_free;

    assign admit = (i_dst_port == udp_proto_pkg::ECHO_PORT) &&
                   (pay_len <= udp_proto_pkg::udp_len_t'(free_now)) &&
                   !i_hdr_full;

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= echo_buf_pkg::RX_IDLE;
            o_payload_wr <= 1'b0;
            o_hdr_wr     <= 1'b0;
            recheck      <= 1'b0;
        end else begin
            o_payload_wr <= 1'b0;
            o_hdr_wr     <= 1'b0;
            recheck      <= 1'b0;
            case (state)
                echo_buf_pkg::RX_IDLE: begin
                    if (i_hdr_valid) begin
                        if (admit) begin
                            state <= echo_buf_pkg::RX_PASS;
                            // Previous reply header lands this cycle, so o_full is stale
                            recheck <= o_hdr_wr;
                        end else begin
                            state <= echo_buf_pkg::RX_DISCARD;
                        end
                    end
                end
                echo_buf_pkg::RX_PASS: begin
                    if (recheck && i_hdr_full) begin
                        // Queue filled by the header in flight, drop this datagram
                        if (i_pay_valid && i_pay_last) begin
                            state <= echo_buf_pkg::RX_IDLE;
                        end else begin
                            state <= echo_buf_pkg::RX_DISCARD;
                        end
                    end else if (i_pay_valid) begin
                        o_payload_wr <= 1'b1;
                        if (i_pay_last) begin
                            o_hdr_wr <= 1'b1;
                            state    <= echo_buf_pkg::RX_IDLE;
                        end
                    end
                end
                echo_buf_pkg::RX_DISCARD: begin
                    if (i_pay_valid && i_pay_last) begin
                        state <= echo_buf_pkg::RX_IDLE;
                    end
                end
                default: state <= echo_buf_pkg::RX_IDLE;
            endcase
        end
    end

    // Swapped reply header, held until the next header strobe
    always_ff @(posedge clk) begin
        o_payload_data <= i_pay_data;
        if (state == echo_buf_pkg::RX_IDLE && i_hdr_valid) begin
            o_hdr_data.dst_ip   <= i_src_ip;
            o_hdr_data.src_port <= i_dst_port;
            o_hdr_data.dst_port <= i_src_port;
            o_hdr_data.length   <= i_length;
        end
    end

endmodule

// ==== hdl/sync_fifo.sv ====
// Single-clock show-ahead FIFO, head data valid whenever o_empty is low
// Writes when full and reads when empty are not guarded
`timescale 1ns/1ps

module sync_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 16
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       i_wr,
    input  logic [WIDTH-1:0]           i_wr_data,
    input  logic                       i_rd,
    output logic [WIDTH-1:0]           o_rd_data,
    output logic                       o_empty,
    output logic                       o_full,
    output logic [$clog2(DEPTH+1)-1:0] o_free
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    always_ff @(posedge clk) begin
        if (i_wr) begin
            mem[wr_ptr] <= i_wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (i_wr) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (i_rd) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous write and read leave the count unchanged
            case ({i_wr, i_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Head entry straight from the array
    assign o_rd_data = mem[rd_ptr];
    assign o_empty   = (count == '0);
    assign o_full    = (count == CNT_W'(DEPTH));
    assign o_free    = CNT_W'(DEPTH) - count;

endmodule

// ==== hdl/echo_buf_pkg.sv ====
// Buffer sizes, header queue word and FSM states of the echo path
// Payload and header depths bound how many datagrams wait for the transmit side
package echo_buf_pkg;

    // Payload buffer size in bytes
    localparam int PAYLOAD_DEPTH = 64;

    // Number of reply headers that can wait in the queue
    localparam int HDR_DEPTH = 4;

    // Width of a free-entry count of the payload buffer
    localparam int PAYLOAD_CNT_W = $clog2(PAYLOAD_DEPTH + 1);

    // Reply header as stored in the header queue, 80 bits
    typedef struct packed {
        udp_proto_pkg::ip_addr_t  dst_ip;
        udp_proto_pkg::udp_port_t src_port;
        udp_proto_pkg::udp_port_t dst_port;
        udp_proto_pkg::udp_len_t  length;
    } reply_hdr_t;

    typedef enum logic [1:0] {RX_IDLE, RX_PASS, RX_DISCARD} rx_state_t;

    typedef enum logic [1:0] {TX_IDLE, TX_HEADER, TX_PAYLOAD} tx_state_t;

endpackage

// ==== hdl/udp_proto_pkg.sv ====
// UDP field types and constants for already parsed datagrams
// Lengths include the 8-byte UDP header, as on the wire
package udp_proto_pkg;

    // IPv4 address
    typedef logic [31:0] ip_addr_t;

    // UDP port number
    typedef logic [15:0] udp_port_t;

    // UDP length in bytes, header included
    typedef logic [15:0] udp_len_t;

    // Destination port that gets echoed back
    localparam udp_port_t ECHO_PORT = 16'd1234;

    // UDP header size, subtract from the length to get the payload size
    localparam udp_len_t UDP_HDR_BYTES = 16'd8;

endpackage
